// ==== source/soc_periph_ao_pkg.sv ====
`default_nettype none

package soc_periph_ao_pkg;

  // ------------------------------
  // Bus and sequencer sizes
  // ------------------------------
  localparam int APB_ADDR_W = 12;
  localparam int APB_DATA_W = 32;
  localparam int APB_STRB_W = APB_DATA_W / 8;

  localparam int AUTO_RELEASE_CYCLES = 8;
  localparam int SEQ_CNT_W = $clog2(AUTO_RELEASE_CYCLES);

  // ------------------------------
  // Register map
  // ------------------------------
  localparam logic [APB_ADDR_W-1:0] ADDR_PART_CTRL   = 12'h000;
  localparam logic [APB_ADDR_W-1:0] ADDR_PART_STATUS = 12'h004;
  localparam logic [APB_ADDR_W-1:0] ADDR_REF_CLK_SEL = 12'h008;
  localparam logic [APB_ADDR_W-1:0] ADDR_IO_DRIVE    = 12'h00C;
  localparam logic [APB_ADDR_W-1:0] ADDR_IO_SCHMITT  = 12'h010;
  localparam logic [APB_ADDR_W-1:0] ADDR_IO_PULL     = 12'h014;
  localparam logic [APB_ADDR_W-1:0] ADDR_GPIO_PD_EN  = 12'h018;

  // Writable bits
  localparam logic [APB_DATA_W-1:0] MASK_PART_CTRL   = 32'h0000_001F;
  localparam logic [APB_DATA_W-1:0] MASK_REF_CLK_SEL = 32'h0000_0003;
  localparam logic [APB_DATA_W-1:0] MASK_IO_DRIVE    = 32'h0001_FFFF;
  localparam logic [APB_DATA_W-1:0] MASK_IO_SCHMITT  = 32'h0000_00FF;
  localparam logic [APB_DATA_W-1:0] MASK_IO_PULL     = 32'h0000_01FF;
  localparam logic [APB_DATA_W-1:0] MASK_GPIO_PD_EN  = 32'h0000_FFFF;

  localparam logic [APB_DATA_W-1:0] RST_REF_CLK_SEL = 32'h0000_0000;
  localparam logic [APB_DATA_W-1:0] RST_IO_DRIVE    = 32'h0000_0000;
  localparam logic [APB_DATA_W-1:0] RST_IO_SCHMITT  = 32'h0000_00FF;
  // Bootmode bit 0 pulled up out of reset
  localparam logic [APB_DATA_W-1:0] RST_IO_PULL     = 32'h0000_0040;
  localparam logic [APB_DATA_W-1:0] RST_GPIO_PD_EN  = 32'h0000_0000;

  // PART_CTRL bit positions
  localparam int CTRL_PERIPH_CLKEN = 0;
  localparam int CTRL_EMMC_CLKEN   = 1;
  localparam int CTRL_PERIPH_RST   = 2;
  localparam int CTRL_EMMC_RST     = 3;
  localparam int CTRL_FENCE_REQ    = 4;

  localparam logic [APB_DATA_W-1:0] PART_CTRL_CLKEN = 32'h0000_0003;
  localparam logic [APB_DATA_W-1:0] PART_CTRL_RUN   = 32'h0000_000F;

  // PART_STATUS bit positions
  localparam int STAT_IDLE_ACK = 0;
  localparam int STAT_IDLE_VAL = 1;
  localparam int STAT_SEQ_DONE = 2;

  // ------------------------------
  // Types
  // ------------------------------
  typedef enum logic [2:0] {
    REG_PART_CTRL,
    REG_PART_STATUS,
    REG_REF_CLK_SEL,
    REG_IO_DRIVE,
    REG_IO_SCHMITT,
    REG_IO_PULL,
    REG_GPIO_PD_EN,
    REG_NONE
  } reg_idx_e;

  typedef enum logic [1:0] {
    ST_HOLD,
    ST_CLKEN,
    ST_RUN
  } seq_state_e;

  typedef struct packed {
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
    logic                  pwrite;
    logic                  psel;
    logic                  penable;
    logic [APB_STRB_W-1:0] pstrb;
  } apb_req_t;

  typedef struct packed {
    logic                  pready;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pslverr;
  } apb_rsp_t;

  typedef struct packed {
    reg_idx_e              idx;
    logic [APB_DATA_W-1:0] wdata;
    logic [APB_STRB_W-1:0] wstrb;
    logic                  en;
  } reg_wr_t;

  typedef struct packed {
    logic periph_clken;
    logic emmc_clken;
    logic periph_rst_n;
    logic emmc_rst_n;
    logic noc_idle_req;
    logic noc_clken;
    logic noc_rst_n;
  } part_out_t;

  typedef struct packed {
    logic [1:0]  ref_clk_sel_freq;
    logic [1:0]  jtag_drive;
    logic [1:0]  uart_drive;
    logic [1:0]  spi_drive;
    logic [1:0]  i2c_drive;
    logic [1:0]  gpio_drive;
    logic [1:0]  obs_drive;
    logic [1:0]  dft_drive;
    logic [2:0]  emmc_drive;
    logic        clk_schmitt;
    logic        rst_schmitt;
    logic        spi_schmitt;
    logic        uart_schmitt;
    logic        i2c_schmitt;
    logic        gpio_schmitt;
    logic        emmc_schmitt;
    logic        dft_schmitt;
    logic [3:0]  spi_sd_pd_en;
    logic        uart_cts_n_pd_en;
    logic        uart_rx_pd_en;
    logic [2:0]  bootmode_pull_en;
    logic [15:0] gpio_pd_en;
  } pad_cfg_t;

  // Byte-strobed write merge, bits outside the mask stay zero
  function automatic logic [APB_DATA_W-1:0] reg_merge(
    input logic [APB_DATA_W-1:0] old_val,
    input logic [APB_DATA_W-1:0] wdata,
    input logic [APB_STRB_W-1:0] wstrb,
    input logic [APB_DATA_W-1:0] mask
  );
    logic [APB_DATA_W-1:0] bit_en;
    for (int b = 0; b < APB_STRB_W; b++) begin
      bit_en[8*b +: 8] = {8{wstrb[b]}};
    end
    bit_en = bit_en & mask;
    return ((old_val & ~bit_en) | (wdata & bit_en)) & mask;
  endfunction

endpackage

`default_nettype wire

// ==== source/apb_cfg_slave.sv ====
`default_nettype none

module apb_cfg_slave
  import soc_periph_ao_pkg::*;
(
  input  logic                  i_ref_clk,
  input  logic                  i_reset,

  input  apb_req_t              i_apb,
  output apb_rsp_t              o_apb,

  output reg_wr_t               o_wr,
  output reg_idx_e              o_idx,

  input  logic [APB_DATA_W-1:0] i_part_rdata,
  input  logic [APB_DATA_W-1:0] i_pad_rdata,
  input  logic                  i_idx_read_only
);

  logic                  setup_phase;
  logic                  access_phase;
  logic                  acc_err;
  logic                  err_q;
  logic [APB_DATA_W-1:0] rdata;
  reg_idx_e              idx;

  assign setup_phase  = i_apb.psel & ~i_apb.penable;
  assign access_phase = i_apb.psel & i_apb.penable;

  // ------------------------------
  // Address decode
  // ------------------------------
  always_comb begin
    case (i_apb.paddr)
      ADDR_PART_CTRL:   idx = REG_PART_CTRL;
      ADDR_PART_STATUS: idx = REG_PART_STATUS;
      ADDR_REF_CLK_SEL: idx = REG_REF_CLK_SEL;
      ADDR_IO_DRIVE:    idx = REG_IO_DRIVE;
      ADDR_IO_SCHMITT:  idx = REG_IO_SCHMITT;
      ADDR_IO_PULL:     idx = REG_IO_PULL;
      ADDR_GPIO_PD_EN:  idx = REG_GPIO_PD_EN;
      default:          idx = REG_NONE;
    endcase
  end

  assign o_idx = idx;

  // Unmapped or write to a read-only register
  assign acc_err = (idx == REG_NONE) | (i_apb.pwrite & i_idx_read_only);

  // Captured in setup, address is stable through the access phase
  always_ff @(posedge i_ref_clk) begin
    if (i_reset) begin
      err_q <= 1'b0;
    end else if (setup_phase) begin
      err_q <= acc_err;
    end
  end

  // ------------------------------
  // Write command
  // ------------------------------
  always_comb begin
    o_wr.idx   = idx;
    o_wr.wdata = i_apb.pwdata;
    o_wr.wstrb = i_apb.pstrb;
    o_wr.en    = access_phase & i_apb.pwrite & ~err_q;
  end

  // Read mux
  always_comb begin
    case (idx)
      REG_PART_CTRL,
      REG_PART_STATUS: rdata = i_part_rdata;
      REG_NONE:        rdata = '0;
      default:         rdata = i_pad_rdata;
    endcase
  end

  always_comb begin
    o_apb.pready  = access_phase;
    o_apb.prdata  = (access_phase & ~i_apb.pwrite) ? rdata : '0;
    o_apb.pslverr = access_phase & err_q;
  end

endmodule

`default_nettype wire

// ==== source/partition_ctrl.sv ====
`default_nettype none

module partition_ctrl
  import soc_periph_ao_pkg::*;
(
  input  logic                  i_ref_clk,
  input  logic                  i_reset,

  input  reg_wr_t               i_wr,
  input  reg_idx_e              i_idx,
  output logic [APB_DATA_W-1:0] o_rdata,
  output logic                  o_read_only,

  input  logic                  i_noc_async_idle_ack,
  input  logic                  i_noc_async_idle_val,

  output part_out_t             o_part
);

  seq_state_e            state_q;
  logic [SEQ_CNT_W-1:0]  cnt_q;
  logic [APB_DATA_W-1:0] ctrl_q;
  logic [APB_DATA_W-1:0] status;
  logic                  seq_done;
  logic                  ctrl_wr;

  assign seq_done = (state_q == ST_RUN);

  // Software only owns PART_CTRL once released
  assign ctrl_wr = seq_done & i_wr.en & (i_wr.idx == REG_PART_CTRL);

  // ------------------------------
  // Release sequencer
  // ------------------------------
  always_ff @(posedge i_ref_clk) begin
    if (i_reset) begin
      state_q <= ST_HOLD;
      cnt_q   <= '0;
      ctrl_q  <= '0;
    end else begin
      case (state_q)
        ST_HOLD: begin
          cnt_q <= cnt_q + SEQ_CNT_W'(1);
          if (cnt_q == SEQ_CNT_W'(AUTO_RELEASE_CYCLES - 1)) begin
            state_q <= ST_CLKEN;
            ctrl_q  <= PART_CTRL_CLKEN;
          end
        end
        // Clocks run one cycle before resets lift
        ST_CLKEN: begin
          state_q <= ST_RUN;
          ctrl_q  <= PART_CTRL_RUN;
        end
        default: begin
          if (ctrl_wr) begin
            ctrl_q <= reg_merge(ctrl_q, i_wr.wdata, i_wr.wstrb, MASK_PART_CTRL);
          end
        end
      endcase
    end
  end

  // ------------------------------
  // Partition and fence outputs
  // ------------------------------
  always_comb begin
    o_part.periph_clken = ctrl_q[CTRL_PERIPH_CLKEN];
    o_part.emmc_clken   = ctrl_q[CTRL_EMMC_CLKEN];
    o_part.periph_rst_n = ctrl_q[CTRL_PERIPH_RST];
    o_part.emmc_rst_n   = ctrl_q[CTRL_EMMC_RST];
    o_part.noc_idle_req = ctrl_q[CTRL_FENCE_REQ];
    // NoC clock stops only behind an acknowledged fence
    o_part.noc_clken    = ctrl_q[CTRL_PERIPH_CLKEN]
                        | ~(ctrl_q[CTRL_FENCE_REQ] & i_noc_async_idle_ack);
    o_part.noc_rst_n    = ctrl_q[CTRL_PERIPH_RST];
  end

  always_comb begin
    status                = '0;
    status[STAT_IDLE_ACK] = i_noc_async_idle_ack;
    status[STAT_IDLE_VAL] = i_noc_async_idle_val;
    status[STAT_SEQ_DONE] = seq_done;
  end

  // Register read back
  always_comb begin
    case (i_idx)
      REG_PART_CTRL:   o_rdata = ctrl_q;
      REG_PART_STATUS: o_rdata = status;
      default:         o_rdata = '0;
    endcase
  end

  assign o_read_only = (i_idx == REG_PART_STATUS);

endmodule

`default_nettype wire

// ==== source/pad_ctrl_regs.sv ====
`default_nettype none

module pad_ctrl_regs
  import soc_periph_ao_pkg::*;
(
  input  logic                  i_ref_clk,
  input  logic                  i_reset,

  input  reg_wr_t               i_wr,
  input  reg_idx_e              i_idx,
  output logic [APB_DATA_W-1:0] o_rdata,

  output pad_cfg_t              o_pad_cfg
);

  logic [APB_DATA_W-1:0] ref_clk_sel_q;
  logic [APB_DATA_W-1:0] io_drive_q;
  logic [APB_DATA_W-1:0] io_schmitt_q;
  logic [APB_DATA_W-1:0] io_pull_q;
  logic [APB_DATA_W-1:0] gpio_pd_en_q;

  // ------------------------------
  // Register file
  // ------------------------------
  always_ff @(posedge i_ref_clk) begin
    if (i_reset) begin
      ref_clk_sel_q <= RST_REF_CLK_SEL;
      io_drive_q    <= RST_IO_DRIVE;
      io_schmitt_q  <= RST_IO_SCHMITT;
      io_pull_q     <= RST_IO_PULL;
      gpio_pd_en_q  <= RST_GPIO_PD_EN;
    end else if (i_wr.en) begin
      case (i_wr.idx)
        REG_REF_CLK_SEL:
          ref_clk_sel_q <= reg_merge(ref_clk_sel_q, i_wr.wdata, i_wr.wstrb, MASK_REF_CLK_SEL);
        REG_IO_DRIVE:
          io_drive_q <= reg_merge(io_drive_q, i_wr.wdata, i_wr.wstrb, MASK_IO_DRIVE);
        REG_IO_SCHMITT:
          io_schmitt_q <= reg_merge(io_schmitt_q, i_wr.wdata, i_wr.wstrb, MASK_IO_SCHMITT);
        REG_IO_PULL:
          io_pull_q <= reg_merge(io_pull_q, i_wr.wdata, i_wr.wstrb, MASK_IO_PULL);
        REG_GPIO_PD_EN:
          gpio_pd_en_q <= reg_merge(gpio_pd_en_q, i_wr.wdata, i_wr.wstrb, MASK_GPIO_PD_EN);
        default: ;
      endcase
    end
  end

  always_comb begin
    case (i_idx)
      REG_REF_CLK_SEL: o_rdata = ref_clk_sel_q;
      REG_IO_DRIVE:    o_rdata = io_drive_q;
      REG_IO_SCHMITT:  o_rdata = io_schmitt_q;
      REG_IO_PULL:     o_rdata = io_pull_q;
      REG_GPIO_PD_EN:  o_rdata = gpio_pd_en_q;
      default:         o_rdata = '0;
    endcase
  end

  // ------------------------------
  // Pad field unpacking
  // ------------------------------
  always_comb begin
    o_pad_cfg.ref_clk_sel_freq = ref_clk_sel_q[1:0];

    o_pad_cfg.jtag_drive = io_drive_q[1:0];
    o_pad_cfg.uart_drive = io_drive_q[3:2];
    o_pad_cfg.spi_drive  = io_drive_q[5:4];
    o_pad_cfg.i2c_drive  = io_drive_q[7:6];
    o_pad_cfg.gpio_drive = io_drive_q[9:8];
    o_pad_cfg.obs_drive  = io_drive_q[11:10];
    o_pad_cfg.dft_drive  = io_drive_q[13:12];
    o_pad_cfg.emmc_drive = io_drive_q[16:14];

    o_pad_cfg.clk_schmitt  = io_schmitt_q[0];
    o_pad_cfg.rst_schmitt  = io_schmitt_q[1];
    o_pad_cfg.spi_schmitt  = io_schmitt_q[2];
    o_pad_cfg.uart_schmitt = io_schmitt_q[3];
    o_pad_cfg.i2c_schmitt  = io_schmitt_q[4];
    o_pad_cfg.gpio_schmitt = io_schmitt_q[5];
    o_pad_cfg.emmc_schmitt = io_schmitt_q[6];
    o_pad_cfg.dft_schmitt  = io_schmitt_q[7];

    // Bootmode 0 is a pull-up, the rest pull down
    o_pad_cfg.spi_sd_pd_en     = io_pull_q[3:0];
    o_pad_cfg.uart_cts_n_pd_en = io_pull_q[4];
    o_pad_cfg.uart_rx_pd_en    = io_pull_q[5];
    o_pad_cfg.bootmode_pull_en = io_pull_q[8:6];

    o_pad_cfg.gpio_pd_en = gpio_pd_en_q[15:0];
  end

endmodule

`default_nettype wire

// ==== source/soc_periph_ao.sv ====
`default_nettype none

module soc_periph_ao
  import soc_periph_ao_pkg::*;
(
  input  logic      i_ref_clk,
  input  logic      i_reset,

  // Config APB
  input  apb_req_t  i_cfg_apb,
  output apb_rsp_t  o_cfg_apb,

  // NoC fence
  input  logic      i_noc_async_idle_ack,
  input  logic      i_noc_async_idle_val,

  output part_out_t o_part,
  output pad_cfg_t  o_pad_cfg
);

  reg_wr_t               cfg_wr;
  reg_idx_e              cfg_idx;
  logic [APB_DATA_W-1:0] part_rdata;
  logic [APB_DATA_W-1:0] pad_rdata;
  logic                  idx_read_only;

  apb_cfg_slave u_apb_cfg_slave (
    .i_ref_clk       (i_ref_clk),
    .i_reset         (i_reset),
    .i_apb           (i_cfg_apb),
    .o_apb           (o_cfg_apb),
    .o_wr            (cfg_wr),
    .o_idx           (cfg_idx),
    .i_part_rdata    (part_rdata),
    .i_pad_rdata     (pad_rdata),
    .i_idx_read_only (idx_read_only)
  );

  partition_ctrl u_partition_ctrl (
    .i_ref_clk            (i_ref_clk),
    .i_reset              (i_reset),
    .i_wr                 (cfg_wr),
    .i_idx                (cfg_idx),
    .o_rdata              (part_rdata),
    .o_read_only          (idx_read_only),
    .i_noc_async_idle_ack (i_noc_async_idle_ack),
    .i_noc_async_idle_val (i_noc_async_idle_val),
    .o_part               (o_part)
  );

  pad_ctrl_regs u_pad_ctrl_regs (
    .i_ref_clk (i_ref_clk),
    .i_reset   (i_reset),
    .i_wr      (cfg_wr),
    .i_idx     (cfg_idx),
    .o_rdata   (pad_rdata),
    .o_pad_cfg (o_pad_cfg)
  );

endmodule

`default_nettype wire

// ==== tests/tb_soc_periph_ao.sv ====
`default_nettype none

module tb_soc_periph_ao
  import soc_periph_ao_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_RAND_WRITES   = 48;
  localparam int NUM_RAND_ACCESSES = 2 * NUM_RAND_WRITES;
  localparam int WATCHDOG_CYCLES   = NUM_RAND_ACCESSES * 4 + 400;
  localparam int PREADY_LIMIT      = 8;

  logic      clk = 1'b0;
  logic      rst;
  apb_req_t  cfg_apb;
  apb_rsp_t  o_cfg_apb;
  logic      noc_ack;
  logic      noc_val;
  part_out_t o_part;
  pad_cfg_t  o_pad_cfg;

  logic [APB_ADDR_W-1:0] reg_addr [7];
  logic [APB_DATA_W-1:0] reg_mask [7];
  logic [APB_DATA_W-1:0] shadow   [7];
  logic [31:0] lcg_state = 32'hf531;
  logic pad_check_en  = 1'b0;
  logic part_check_en = 1'b0;
  int error_count    = 0;
  int check_count    = 0;
  int test_num       = 0;
  int test_err_start = 0;
  int sample_cnt     = 0;
  int clken_first    = -1;
  int rstn_first     = -1;

  always #10 clk = ~clk;

  soc_periph_ao u_dut (
    .i_ref_clk            (clk),
    .i_reset              (rst),
    .i_cfg_apb            (cfg_apb),
    .o_cfg_apb            (o_cfg_apb),
    .i_noc_async_idle_ack (noc_ack),
    .i_noc_async_idle_val (noc_val),
    .o_part               (o_part),
    .o_pad_cfg            (o_pad_cfg)
  );

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Strobed byte merge with reserved bits forced to zero
  function automatic logic [31:0] merged_value(input logic [31:0] old_val,
      input logic [31:0] wdata, input logic [3:0] strb, input logic [31:0] mask);
    logic [31:0] result;
    result = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return result & mask;
  endfunction

  function automatic pad_cfg_t pad_from_shadow();
    pad_cfg_t p;
    p.ref_clk_sel_freq = shadow[2][1:0];
    p.jtag_drive       = shadow[3][1:0];
    p.uart_drive       = shadow[3][3:2];
    p.spi_drive        = shadow[3][5:4];
    p.i2c_drive        = shadow[3][7:6];
    p.gpio_drive       = shadow[3][9:8];
    p.obs_drive        = shadow[3][11:10];
    p.dft_drive        = shadow[3][13:12];
    p.emmc_drive       = shadow[3][16:14];
    {p.dft_schmitt, p.emmc_schmitt, p.gpio_schmitt, p.i2c_schmitt,
     p.uart_schmitt, p.spi_schmitt, p.rst_schmitt, p.clk_schmitt} = shadow[4][7:0];
    p.spi_sd_pd_en     = shadow[5][3:0];
    p.uart_cts_n_pd_en = shadow[5][4];
    p.uart_rx_pd_en    = shadow[5][5];
    p.bootmode_pull_en = shadow[5][8:6];
    p.gpio_pd_en       = shadow[6][15:0];
    return p;
  endfunction

  function automatic part_out_t part_from_ctrl(input logic [31:0] ctrl, input logic ack);
    part_out_t p;
    p.periph_clken = ctrl[0];
    p.emmc_clken   = ctrl[1];
    p.periph_rst_n = ctrl[2];
    p.emmc_rst_n   = ctrl[3];
    p.noc_idle_req = ctrl[4];
    p.noc_clken    = ctrl[0] | ~(ctrl[4] & ack);
    p.noc_rst_n    = ctrl[2];
    return p;
  endfunction

  function automatic logic [31:0] status_word(input logic done, input logic val,
      input logic ack);
    return {29'd0, done, val, ack};
  endfunction

  function automatic logic is_mapped(input logic [11:0] addr);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < 7; i++) begin
      if (reg_addr[i] == addr) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // ------------------------------
  // Checks and bus access
  // ------------------------------
  task automatic check_value(input string name, input logic [63:0] exp,
      input logic [63:0] act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("Error %s expected %h actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic apb_access(input logic [11:0] addr, input logic [31:0] wdata,
      input logic [3:0] strb, input logic write, input logic exp_err,
      output logic [31:0] rdata);
    apb_req_t req;
    int       wait_cnt;
    req.paddr   = addr;
    req.pwdata  = write ? wdata : 32'h0;
    req.pwrite  = write;
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pstrb   = write ? strb : 4'h0;
    @(posedge clk);
    cfg_apb <= req;
    req.penable = 1'b1;
    @(posedge clk);
    cfg_apb <= req;
    @(negedge clk);
    wait_cnt = 0;
    while (o_cfg_apb.pready !== 1'b1 && wait_cnt < PREADY_LIMIT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (o_cfg_apb.pready !== 1'b1) begin
      error_count++;
      $display("APB access to address %h never got pready", addr);
    end else if (wait_cnt != 0) begin
      error_count++;
      $display("APB access to address %h took %0d wait states instead of none",
               addr, wait_cnt);
    end
    rdata = o_cfg_apb.prdata;
    check_value("pslverr", 64'(exp_err), 64'(o_cfg_apb.pslverr));
    @(posedge clk);
    cfg_apb <= '0;
  endtask

  task automatic start_test();
    test_num++;
    test_err_start = error_count;
  endtask

  task automatic finish_test(input string name);
    $display("Test %0d %s: %s, %0d errors", test_num, name,
             (error_count == test_err_start) ? "ok" : "mismatches",
             error_count - test_err_start);
  endtask

  // Output compare against the shadows on every falling edge
  always @(negedge clk) begin
    if (pad_check_en) begin
      check_value("o_pad_cfg", 64'(pad_from_shadow()), 64'(o_pad_cfg));
    end
    if (part_check_en) begin
      check_value("o_part", 64'(part_from_ctrl(shadow[0], noc_ack)), 64'(o_part));
    end
  end

  // First samples of clock enable and reset release
  always @(negedge clk) begin
    sample_cnt++;
    if (clken_first < 0 && o_part.periph_clken && o_part.emmc_clken) begin
      clken_first = sample_cnt;
    end
    if (rstn_first < 0 && o_part.periph_rst_n && o_part.emmc_rst_n) begin
      rstn_first = sample_cnt;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    logic [31:0] rdata;
    logic [31:0] rnd;
    logic [31:0] wdata;
    logic [31:0] exp_rd;
    logic [3:0]  strb;
    logic [11:0] addr;
    logic        done;
    int          r;
    int          poll;
    logic [11:0] bad_addr [4];

    rst     = 1'b1;
    cfg_apb = '0;
    noc_ack = 1'b0;
    noc_val = 1'b0;
    reg_addr = '{ADDR_PART_CTRL, ADDR_PART_STATUS, ADDR_REF_CLK_SEL, ADDR_IO_DRIVE,
                 ADDR_IO_SCHMITT, ADDR_IO_PULL, ADDR_GPIO_PD_EN};
    reg_mask = '{MASK_PART_CTRL, 32'h0, MASK_REF_CLK_SEL, MASK_IO_DRIVE,
                 MASK_IO_SCHMITT, MASK_IO_PULL, MASK_GPIO_PD_EN};
    shadow   = '{32'h0, 32'h0, RST_REF_CLK_SEL, RST_IO_DRIVE,
                 RST_IO_SCHMITT, RST_IO_PULL, RST_GPIO_PD_EN};
    bad_addr = '{12'h01C, 12'h002, 12'h100, 12'hFFC};

    @(posedge clk);
    pad_check_en  = 1'b1;
    part_check_en = 1'b1;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // Early PART_CTRL write is ignored while the partitions are held
    start_test();
    apb_access(ADDR_PART_CTRL, 32'h1F, 4'hF, 1'b1, 1'b0, rdata);
    apb_access(ADDR_PART_STATUS, 32'h0, 4'h0, 1'b0, 1'b0, rdata);
    check_value("prdata", 64'(status_word(1'b0, 1'b0, 1'b0)), 64'(rdata));
    part_check_en = 1'b0;
    for (int i = 2; i < 7; i++) begin
      apb_access(reg_addr[i], 32'h0, 4'h0, 1'b0, 1'b0, rdata);
      check_value("prdata", 64'(shadow[i]), 64'(rdata));
    end
    finish_test("reset values");

    start_test();
    done = 1'b0;
    poll = 0;
    while (!done && poll < 20) begin
      apb_access(ADDR_PART_STATUS, 32'h0, 4'h0, 1'b0, 1'b0, rdata);
      done = rdata[2];
      poll++;
    end
    if (!done) begin
      error_count++;
      $display("Sequence done never rose in PART_STATUS");
    end
    check_value("prdata", 64'(status_word(1'b1, 1'b0, 1'b0)), 64'(rdata));
    apb_access(ADDR_PART_CTRL, 32'h0, 4'h0, 1'b0, 1'b0, rdata);
    check_value("prdata", 64'(PART_CTRL_RUN), 64'(rdata));
    check_value("rst_n_first_sample", 64'(clken_first + 1), 64'(rstn_first));
    shadow[0]     = PART_CTRL_RUN;
    part_check_en = 1'b1;
    finish_test("auto release");

    start_test();
    for (int n = 0; n < NUM_RAND_WRITES; n++) begin
      rnd   = lcg_next();
      r     = 2 + int'((rnd >> 16) % 32'd5);
      wdata = lcg_next();
      rnd   = lcg_next();
      strb  = rnd[19:16];
      apb_access(reg_addr[r], wdata, strb, 1'b1, 1'b0, rdata);
      shadow[r] = merged_value(shadow[r], wdata, strb, reg_mask[r]);
      apb_access(reg_addr[r], 32'h0, 4'h0, 1'b0, 1'b0, rdata);
      check_value("prdata", 64'(shadow[r]), 64'(rdata));
    end
    finish_test("random strobed writes");

    start_test();
    for (int k = 0; k < 8; k++) begin
      if (k < 4) begin
        addr = bad_addr[k];
      end else begin
        do begin
          rnd  = lcg_next();
          addr = rnd[27:16];
        end while (is_mapped(addr));
      end
      apb_access(addr, lcg_next(), 4'hF, 1'b1, 1'b1, rdata);
      apb_access(addr, 32'h0, 4'h0, 1'b0, 1'b1, rdata);
    end
    apb_access(ADDR_PART_STATUS, 32'hFFFF_FFFF, 4'hF, 1'b1, 1'b1, rdata);
    for (int i = 0; i < 7; i++) begin
      exp_rd = (i == 1) ? status_word(1'b1, noc_val, noc_ack) : shadow[i];
      apb_access(reg_addr[i], 32'h0, 4'h0, 1'b0, 1'b0, rdata);
      check_value("prdata", 64'(exp_rd), 64'(rdata));
    end
    finish_test("error response");

    start_test();
    wdata = shadow[0] | 32'h10;
    apb_access(ADDR_PART_CTRL, wdata, 4'h1, 1'b1, 1'b0, rdata);
    shadow[0] = merged_value(shadow[0], wdata, 4'h1, MASK_PART_CTRL);
    @(negedge clk);
    check_value("noc_idle_req", 64'(1'b1), 64'(o_part.noc_idle_req));
    // Periph clock off before the fence is acknowledged
    wdata = shadow[0] & ~32'h1;
    apb_access(ADDR_PART_CTRL, wdata, 4'h1, 1'b1, 1'b0, rdata);
    shadow[0] = merged_value(shadow[0], wdata, 4'h1, MASK_PART_CTRL);
    @(negedge clk);
    check_value("noc_clken", 64'(1'b1), 64'(o_part.noc_clken));
    @(posedge clk);
    noc_ack <= 1'b1;
    @(negedge clk);
    check_value("noc_clken", 64'(1'b0), 64'(o_part.noc_clken));
    for (int k = 0; k < 4; k++) begin
      rnd = lcg_next();
      @(posedge clk);
      noc_ack <= rnd[16];
      noc_val <= rnd[17];
      apb_access(ADDR_PART_STATUS, 32'h0, 4'h0, 1'b0, 1'b0, rdata);
      check_value("prdata", 64'(status_word(1'b1, rnd[17], rnd[16])), 64'(rdata));
    end
    apb_access(ADDR_PART_CTRL, PART_CTRL_RUN, 4'hF, 1'b1, 1'b0, rdata);
    shadow[0] = PART_CTRL_RUN;
    @(negedge clk);
    check_value("noc_clken", 64'(1'b1), 64'(o_part.noc_clken));
    finish_test("fence and NoC gating");

    $display("Tests %0d, checks %0d, errors %0d", test_num, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
source/soc_periph_ao_pkg.sv
source/apb_cfg_slave.sv
source/partition_ctrl.sv
source/pad_ctrl_regs.sv
source/soc_periph_ao.sv
tests/tb_soc_periph_ao.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log for the result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_soc_periph_ao -f src.f \
  -o tb_soc_periph_ao > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_soc_periph_ao > sim.log 2>&1 ; cat sim.log

grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0
